/* Makefile */
# Verilator flow for the crossbar testbench, run from the project root

TOP = bus_xbar_tb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* all.f */
design/bus_cfg_pkg.sv
design/obi_pkg.sv
design/bus_arbiter.sv
design/outstanding_counter.sv
design/addr_decode.sv
design/route_fifo.sv
design/sram_bank.sv
design/bus_xbar_top.sv
verif/bus_xbar_assert.sv
verif/bus_xbar_tb.sv

/* design/addr_decode.sv */
// --------------------------------------------------------------------------
// Fixed decode: interleaved region on banks 0/1, all else to the default bank.
// Default-bank addresses wrap within the bank, so they alias.
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module addr_decode import bus_cfg_pkg::*; (
  input  logic [31:0]           addr_i,
  output logic [SLV_IDX_W-1:0]  slave_idx_o,
  output logic [BANK_IDX_W-1:0] word_idx_o
);

  logic [31:0] ilv_offset;
  logic        in_ilv;

  // Offset form keeps the compare valid for any base
  assign ilv_offset = addr_i - ILV_BASE;
  assign in_ilv     = ilv_offset < ILV_SIZE;

  always_comb begin
    if (in_ilv) begin
      // Bit 2 picks the bank and is dropped from the word index
      slave_idx_o = SLV_IDX_W'(addr_i[2]);
      word_idx_o  = addr_i[BANK_IDX_W+2:3];
    end else begin
      slave_idx_o = SLV_IDX_W'(DEFAULT_SLAVE);
      word_idx_o  = addr_i[BANK_IDX_W+1:2];
    end
  end

endmodule

`default_nettype wire

/* design/bus_arbiter.sv */
// --------------------------------------------------------------------------
// Two-master round-robin arbiter, combinational from req to gnt.
// Priority moves one cycle after a grant; full_i blocks every grant.
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter import bus_cfg_pkg::*; (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic [NUM_MASTERS-1:0] req_i,
  input  logic                   full_i,
  output logic [NUM_MASTERS-1:0] gnt_o,
  output logic [MST_IDX_W-1:0]   gnt_idx_o,
  output logic                   gnt_valid_o
);

  typedef enum logic {
    PRIO_M0,
    PRIO_M1
  } prio_e;

  prio_e state_q;
  prio_e state_d;

  // Pick the favored master first, fall back to the other
  always_comb begin
    gnt_o     = '0;
    gnt_idx_o = '0;
    if (!full_i) begin
      case (state_q)
        PRIO_M0: begin
          if (req_i[0]) begin
            gnt_o[0] = 1'b1;
          end else if (req_i[1]) begin
            gnt_o[1]  = 1'b1;
            gnt_idx_o = 1'b1;
          end
        end
        default: begin
          if (req_i[1]) begin
            gnt_o[1]  = 1'b1;
            gnt_idx_o = 1'b1;
          end else if (req_i[0]) begin
            gnt_o[0] = 1'b1;
          end
        end
      endcase
    end
  end

  assign gnt_valid_o = |gnt_o;

  // Priority passes to the master after the winner
  always_comb begin
    state_d = state_q;
    if (gnt_valid_o) begin
      state_d = gnt_idx_o[0] ? PRIO_M0 : PRIO_M1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= PRIO_M0;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

/* design/bus_cfg_pkg.sv */
// --------------------------------------------------------------------------
// Fixed address map and sizing of the two-master, three-bank OBI crossbar.
// The map cannot be changed at run time. Banks 0/1 interleave on address bit 2.
// --------------------------------------------------------------------------
`default_nettype none

package bus_cfg_pkg;

  // Ports on each side of the neck
  localparam int unsigned NUM_MASTERS = 2;
  localparam int unsigned NUM_SLAVES  = 3;
  localparam int unsigned MST_IDX_W   = 1;
  localparam int unsigned SLV_IDX_W   = 2;

  // Interleaved region served by banks 0 and 1
  localparam logic [31:0] ILV_BASE = 32'h0000_0000;
  localparam logic [31:0] ILV_SIZE = 32'h0000_0800;

  // Everything outside the region goes here
  localparam int unsigned DEFAULT_SLAVE = 2;

  // Bank geometry, in 32-bit words
  localparam int unsigned BANK_WORDS = 256;
  localparam int unsigned BANK_IDX_W = 8;

  // In-flight limit and the widths that follow from it
  localparam int unsigned MAX_OUTSTANDING = 2;
  localparam int unsigned CNT_W           = 2;
  localparam int unsigned PTR_W           = 1;

  // Cycles from the accepting gnt to rvalid
  localparam int unsigned READ_LATENCY = 2;

endpackage

`default_nettype wire

/* design/bus_xbar_top.sv */
// --------------------------------------------------------------------------
// Two masters into one neck, fanned out to three SRAM banks.
// Masters must always take rvalid; there is no response back-pressure.
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module bus_xbar_top import bus_cfg_pkg::*, obi_pkg::*; (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  obi_req_t  [NUM_MASTERS-1:0] master_req_i,
  output obi_resp_t [NUM_MASTERS-1:0] master_resp_o
);

  logic [NUM_MASTERS-1:0]                 mst_req;
  logic [NUM_MASTERS-1:0]                 gnt;
  logic [MST_IDX_W-1:0]                   gnt_idx;
  logic                                   gnt_valid;
  logic                                   bus_full;
  logic [CNT_W-1:0]                       outstanding_cnt;
  obi_req_t                               neck_req;
  logic [SLV_IDX_W-1:0]                   slave_idx;
  logic [BANK_IDX_W-1:0]                  word_idx;
  bank_req_t [NUM_SLAVES-1:0]             bank_req;
  logic [NUM_SLAVES-1:0][OBI_DATA_W-1:0]  bank_rdata;
  logic [NUM_SLAVES-1:0]                  bank_rvalid;
  logic [MST_IDX_W-1:0]                   mst_head;
  logic [SLV_IDX_W-1:0]                   slv_head;
  logic                                   mst_empty;
  logic                                   slv_empty;
  logic                                   bank_hit;
  logic                                   resp_valid;
  logic [OBI_DATA_W-1:0]                  resp_rdata;

  for (genvar m = 0; m < NUM_MASTERS; m++) begin : gen_req
    assign mst_req[m] = master_req_i[m].req;
  end

  bus_arbiter i_bus_arbiter (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .req_i      (mst_req),
    .full_i     (bus_full),
    .gnt_o      (gnt),
    .gnt_idx_o  (gnt_idx),
    .gnt_valid_o(gnt_valid)
  );

  outstanding_counter i_outstanding_counter (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .inc_i  (gnt_valid),
    .dec_i  (resp_valid),
    .count_o(outstanding_cnt),
    .full_o (bus_full)
  );

  // Neck carries the granted master only
  assign neck_req = master_req_i[gnt_idx];

  addr_decode i_addr_decode (
    .addr_i     (neck_req.addr),
    .slave_idx_o(slave_idx),
    .word_idx_o (word_idx)
  );

  for (genvar b = 0; b < NUM_SLAVES; b++) begin : gen_bank
    assign bank_req[b] = '{
      en:       gnt_valid && (slave_idx == SLV_IDX_W'(b)),
      we:       neck_req.we,
      be:       neck_req.be,
      word_idx: word_idx,
      wdata:    neck_req.wdata
    };

    sram_bank i_sram_bank (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .req_i   (bank_req[b]),
      .rdata_o (bank_rdata[b]),
      .rvalid_o(bank_rvalid[b])
    );
  end

  // Route of each grant, in grant order
  route_fifo #(.payload_t(logic [MST_IDX_W-1:0])) mst_fifo (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .push_i (gnt_valid),
    .data_i (gnt_idx),
    .pop_i  (resp_valid),
    .head_o (mst_head),
    .empty_o(mst_empty)
  );

  route_fifo #(.payload_t(logic [SLV_IDX_W-1:0])) slv_fifo (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .push_i (gnt_valid),
    .data_i (slave_idx),
    .pop_i  (resp_valid),
    .head_o (slv_head),
    .empty_o(slv_empty)
  );

  // Oldest route selects the answering bank
  always_comb begin
    bank_hit   = 1'b0;
    resp_rdata = '0;
    for (int b = 0; b < NUM_SLAVES; b++) begin
      if (slv_head == SLV_IDX_W'(b)) begin
        bank_hit   = bank_rvalid[b];
        resp_rdata = bank_rdata[b];
      end
    end
  end

  assign resp_valid = bank_hit && !slv_empty && !mst_empty;

  for (genvar m = 0; m < NUM_MASTERS; m++) begin : gen_resp
    assign master_resp_o[m].gnt    = gnt[m];
    assign master_resp_o[m].rvalid = resp_valid && (mst_head == MST_IDX_W'(m));
    assign master_resp_o[m].rdata  = resp_rdata;
  end

endmodule

`default_nettype wire

/* design/obi_pkg.sv */
// --------------------------------------------------------------------------
// OBI request/response structs and the decoded per-bank request.
// No error or atomic fields are carried.
// --------------------------------------------------------------------------
`default_nettype none

package obi_pkg;
  import bus_cfg_pkg::*;

  localparam int unsigned OBI_ADDR_W = 32;
  localparam int unsigned OBI_DATA_W = 32;
  localparam int unsigned OBI_BE_W   = OBI_DATA_W / 8;

  typedef struct packed {
    logic                  req;
    logic                  we;
    logic [OBI_BE_W-1:0]   be;
    logic [OBI_ADDR_W-1:0] addr;
    logic [OBI_DATA_W-1:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic                  gnt;
    logic                  rvalid;
    logic [OBI_DATA_W-1:0] rdata;
  } obi_resp_t;

  // Request as seen by one SRAM bank after decoding
  typedef struct packed {
    logic                  en;
    logic                  we;
    logic [OBI_BE_W-1:0]   be;
    logic [BANK_IDX_W-1:0] word_idx;
    logic [OBI_DATA_W-1:0] wdata;
  } bank_req_t;

endpackage

`default_nettype wire

/* design/outstanding_counter.sv */
// --------------------------------------------------------------------------
// Up/down count of transactions between gnt and rvalid.
// full_o drops in a draining cycle so the next grant can enter.
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module outstanding_counter import bus_cfg_pkg::*; (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             inc_i,
  input  logic             dec_i,
  output logic [CNT_W-1:0] count_o,
  output logic             full_o
);

  logic [CNT_W-1:0] count_q;

  // Inc and dec together cancel out
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q <= '0;
    end else if (inc_i && !dec_i) begin
      count_q <= count_q + 1'b1;
    end else if (dec_i && !inc_i) begin
      count_q <= count_q - 1'b1;
    end
  end

  assign count_o = count_q;
  assign full_o  = (count_q == CNT_W'(MAX_OUTSTANDING)) && !dec_i;

endmodule

`default_nettype wire

/* design/route_fifo.sv */
// --------------------------------------------------------------------------
// In-order FIFO of response routes, MAX_OUTSTANDING entries deep.
// Overflow is not guarded; the outstanding counter keeps pushes in range.
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module route_fifo import bus_cfg_pkg::*; #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t head_o,
  output logic     empty_o
);

  payload_t         buf_q [MAX_OUTSTANDING];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] fill_q;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    nxt = (ptr == PTR_W'(MAX_OUTSTANDING - 1)) ? '0 : ptr + 1'b1;
    return nxt;
  endfunction

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      if (push_i && !pop_i) begin
        fill_q <= fill_q + 1'b1;
      end else if (pop_i && !push_i) begin
        fill_q <= fill_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      buf_q[wr_ptr_q] <= data_i;
    end
  end

  assign head_o  = buf_q[rd_ptr_q];
  assign empty_o = (fill_q == '0);

endmodule

`default_nettype wire

/* design/sram_bank.sv */
// --------------------------------------------------------------------------
// Single-port word SRAM with byte enables and a fixed two-stage read path.
// Words read as zero until first written; rvalid follows writes as well.
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module sram_bank import bus_cfg_pkg::*, obi_pkg::*; (
  input  logic        clk_i,
  input  logic        reset_i,
  input  bank_req_t   req_i,
  output logic [31:0] rdata_o,
  output logic        rvalid_o
);

  logic [OBI_DATA_W-1:0]   mem_q [BANK_WORDS];
  logic [BANK_WORDS-1:0]   written_q;
  logic [OBI_DATA_W-1:0]   old_word;
  logic [OBI_DATA_W-1:0]   new_word;
  logic [OBI_DATA_W-1:0]   stage1_q;
  logic [OBI_DATA_W-1:0]   stage2_q;
  logic [READ_LATENCY-1:0] vld_pipe_q;

  // Unwritten words look like zero, also for partial writes
  always_comb begin
    old_word = written_q[req_i.word_idx] ? mem_q[req_i.word_idx] : '0;
    for (int b = 0; b < OBI_BE_W; b++) begin
      new_word[8*b +: 8] = req_i.be[b] ? req_i.wdata[8*b +: 8] : old_word[8*b +: 8];
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.en && req_i.we) begin
      mem_q[req_i.word_idx] <= new_word;
    end
    // Stage one samples the array, stage two drives the port
    if (req_i.en) begin
      stage1_q <= old_word;
    end
    stage2_q <= stage1_q;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      written_q  <= '0;
      vld_pipe_q <= '0;
    end else begin
      if (req_i.en && req_i.we) begin
        written_q[req_i.word_idx] <= 1'b1;
      end
      vld_pipe_q <= {vld_pipe_q[READ_LATENCY-2:0], req_i.en};
    end
  end

  assign rdata_o  = stage2_q;
  assign rvalid_o = vld_pipe_q[READ_LATENCY-1];

endmodule

`default_nettype wire

/* verif/bus_trace.txt */
# master we be addr wdata exp_rdata gap, all hex; exp_rdata is ignored for writes
# gap counts cycles after the previous line; gap 0 issues on the other master
0 0 f 00000010 00000000 00000000 1
0 1 f 00000020 11223344 00000000 1
0 0 f 00000020 00000000 11223344 1
0 1 3 00000020 aabbccdd 00000000 1
0 0 f 00000020 00000000 1122ccdd 1
1 1 f 00000024 55667788 00000000 2
1 0 f 00000024 00000000 55667788 1
0 0 f 00000020 00000000 1122ccdd 1
1 1 4 00000024 00990000 00000000 1
1 0 f 00000024 00000000 55997788 1
0 1 f 00001000 deadbeef 00000000 1
1 0 f 00001400 00000000 deadbeef 1
0 0 f 00000800 00000000 deadbeef 1
1 0 f 000007fc 00000000 00000000 1
0 1 f 00000040 01010101 00000000 2
1 1 f 00000044 02020202 00000000 0
0 1 f 00000048 03030303 00000000 1
1 1 f 0000004c 04040404 00000000 0
0 0 f 00000040 00000000 01010101 1
1 0 f 00000044 00000000 02020202 0
0 0 f 00000048 00000000 03030303 1
1 0 f 0000004c 00000000 04040404 0
0 0 f 00000044 00000000 02020202 1
1 0 f 00001000 00000000 deadbeef 0

/* verif/bus_xbar_assert.sv */
// --------------------------------------------------------------------------
// Handshake and counter rules of the crossbar, bound to its top level.
// Checks are disabled while reset is high.
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module bus_xbar_assert import bus_cfg_pkg::*, obi_pkg::*; (
  input logic                        clk_i,
  input logic                        reset_i,
  input obi_req_t  [NUM_MASTERS-1:0] req_i,
  input obi_resp_t [NUM_MASTERS-1:0] resp_i,
  input logic      [NUM_MASTERS-1:0] gnt_i,
  input logic      [CNT_W-1:0]       count_i
);

  logic [NUM_MASTERS-1:0] req_vec;
  logic [NUM_MASTERS-1:0] rvalid_vec;
  int                     fail_count = 0;

  for (genvar m = 0; m < NUM_MASTERS; m++) begin : gen_vec
    assign req_vec[m]    = req_i[m].req;
    assign rvalid_vec[m] = resp_i[m].rvalid;
  end

  // Each master's rvalid is its own gnt, delayed
  rvalid_latency: assert property (@(posedge clk_i) disable iff (reset_i)
    rvalid_vec == $past(gnt_i, READ_LATENCY))
    else begin
      $error("rvalid does not follow gnt by %0d cycles", READ_LATENCY);
      fail_count++;
    end

  gnt_needs_req: assert property (@(posedge clk_i) disable iff (reset_i)
    (gnt_i & ~req_vec) == '0)
    else begin
      $error("gnt without req");
      fail_count++;
    end

  single_gnt: assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(gnt_i))
    else begin
      $error("more than one gnt in a cycle");
      fail_count++;
    end

  count_limit: assert property (@(posedge clk_i) disable iff (reset_i)
    count_i <= CNT_W'(MAX_OUTSTANDING))
    else begin
      $error("outstanding count above limit");
      fail_count++;
    end

endmodule

bind bus_xbar_top bus_xbar_assert i_bus_xbar_assert (
  .clk_i  (clk_i),
  .reset_i(reset_i),
  .req_i  (master_req_i),
  .resp_i (master_resp_o),
  .gnt_i  (gnt),
  .count_i(outstanding_cnt)
);

`default_nettype wire

/* verif/bus_xbar_tb.sv */
// --------------------------------------------------------------------------
// Trace-driven testbench. Pass one checks the trace's own read data; pass two
// uses random gaps and a memory model. Run from the project root.
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module bus_xbar_tb import bus_cfg_pkg::*, obi_pkg::*; ();

  localparam int    CLK_HALF        = 50;
  localparam int    RESET_CYCLES    = 10;
  localparam int    SAMPLE_DELAY    = 10;
  localparam int    CYCLES_PER_LINE = 20;
  localparam string TRACE_FILE      = "verif/bus_trace.txt";

  typedef struct packed {
    logic        mst;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] exp;
    logic [7:0]  gap;
  } trace_line_t;

  // One expected response, due in a fixed cycle
  typedef struct packed {
    logic [31:0] due;
    logic        check;
    logic [31:0] data;
  } resp_exp_t;

  logic                        clk;
  logic                        reset;
  obi_req_t  [NUM_MASTERS-1:0] master_req;
  obi_resp_t [NUM_MASTERS-1:0] master_resp;

  trace_line_t trace_q[$];
  int          pend_q[NUM_MASTERS][$];
  resp_exp_t   resp_q[NUM_MASTERS][$];
  logic [31:0] model_mem [NUM_SLAVES*BANK_WORDS];
  logic [15:0] lfsr_q;
  logic        prio;
  int          cyc;
  bit          trace_loaded;

  bus_xbar_top i_bus_xbar_top (
    .clk_i        (clk),
    .reset_i      (reset),
    .master_req_i (master_req),
    .master_resp_o(master_resp)
  );

  always #CLK_HALF clk = ~clk;

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val = (val << 1) | int'(lfsr_q[0]);
    end
  endtask

  // Bank and word as the address map defines them
  function automatic int model_index(input logic [31:0] addr);
    int idx;
    if (addr - ILV_BASE < ILV_SIZE) begin
      idx = int'(addr[2]) * int'(BANK_WORDS) + int'(addr[10:3]);
    end else begin
      idx = int'(DEFAULT_SLAVE) * int'(BANK_WORDS) + int'(addr[9:2]);
    end
    return idx;
  endfunction

  task automatic model_access(input trace_line_t t, output logic [31:0] rdata);
    int idx;
    idx = model_index(t.addr);
    rdata = model_mem[idx];
    if (t.we) begin
      for (int b = 0; b < 4; b++) begin
        if (t.be[b]) model_mem[idx][8*b +: 8] = t.wdata[8*b +: 8];
      end
    end
  endtask

  task automatic load_trace();
    int          fd;
    int          n;
    string       line;
    logic [31:0] v_mst;
    logic [31:0] v_we;
    logic [31:0] v_be;
    logic [31:0] v_addr;
    logic [31:0] v_wdata;
    logic [31:0] v_exp;
    logic [31:0] v_gap;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the trace file %s", TRACE_FILE);
      $display("TESTS FAILED");
      $fatal(1);
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h",
                      v_mst, v_we, v_be, v_addr, v_wdata, v_exp, v_gap);
          if (n == 7) begin
            trace_q.push_back({v_mst[0], v_we[0], v_be[3:0], v_addr, v_wdata, v_exp,
                               v_gap[7:0]});
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic next_gap(input int idx, input bit use_random, output int gap);
    if (use_random) begin
      take_bits(2, gap);
    end else begin
      gap = int'(trace_q[idx].gap);
    end
  endtask

  function automatic bit work_left();
    bit busy;
    busy = 1'b0;
    for (int m = 0; m < NUM_MASTERS; m++) begin
      busy = busy || pend_q[m].size() > 0 || resp_q[m].size() > 0;
    end
    return busy;
  endfunction

  // One pass over the trace, one loop turn per clock cycle
  task automatic run_pass(input bit use_random);
    int                     next_line;
    int                     release_cyc;
    int                     gap;
    int                     inflight;
    bit                     drain;
    bit                     exp_rv;
    logic [NUM_MASTERS-1:0] req_vec;
    logic [NUM_MASTERS-1:0] gnt_vec;
    logic [NUM_MASTERS-1:0] exp_gnt;
    trace_line_t            t;
    resp_exp_t              r;
    next_line = 0;
    next_gap(0, use_random, gap);
    release_cyc = cyc + gap;
    while (next_line < trace_q.size() || work_left()) begin
      @(negedge clk);
      cyc++;
      while (next_line < trace_q.size() && release_cyc <= cyc) begin
        pend_q[trace_q[next_line].mst].push_back(next_line);
        next_line++;
        if (next_line < trace_q.size()) begin
          next_gap(next_line, use_random, gap);
          release_cyc += gap;
        end
      end
      // A master keeps its request up until granted
      for (int m = 0; m < NUM_MASTERS; m++) begin
        if (pend_q[m].size() > 0) begin
          t = trace_q[pend_q[m][0]];
          master_req[m] = '{req: 1'b1, we: t.we, be: t.be, addr: t.addr, wdata: t.wdata};
        end else begin
          master_req[m] = '0;
        end
      end
      #SAMPLE_DELAY;
      drain = 1'b0;
      inflight = 0;
      for (int m = 0; m < NUM_MASTERS; m++) begin
        inflight += resp_q[m].size();
        exp_rv = resp_q[m].size() > 0 && resp_q[m][0].due == 32'(cyc);
        compare($sformatf("master_resp[%0d].rvalid", m), 32'(master_resp[m].rvalid),
                32'(exp_rv));
        if (exp_rv) begin
          r = resp_q[m].pop_front();
          drain = 1'b1;
          if (r.check) compare($sformatf("master_resp[%0d].rdata", m), master_resp[m].rdata,
                               r.data);
        end
        req_vec[m] = master_req[m].req;
        gnt_vec[m] = master_resp[m].gnt;
      end
      // Round robin, held back only when full with nothing draining
      exp_gnt = '0;
      if (!(inflight >= int'(MAX_OUTSTANDING) && !drain)) begin
        if (&req_vec) exp_gnt[prio] = 1'b1;
        else exp_gnt = req_vec;
      end
      compare("gnt", 32'(gnt_vec), 32'(exp_gnt));
      for (int m = 0; m < NUM_MASTERS; m++) begin
        if (gnt_vec[m]) begin
          t = trace_q[pend_q[m].pop_front()];
          model_access(t, r.data);
          if (!use_random) r.data = t.exp;
          r.due   = 32'(cyc + int'(READ_LATENCY));
          r.check = !t.we;
          resp_q[m].push_back(r);
          prio = (m == 0);
        end
      end
    end
  endtask

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    master_req   = '0;
    lfsr_q       = 16'd34;
    prio         = 1'b0;
    cyc          = 0;
    trace_loaded = 1'b0;
    for (int i = 0; i < NUM_SLAVES * BANK_WORDS; i++) begin
      model_mem[i] = '0;
    end
    load_trace();
    trace_loaded = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    run_pass(1'b0);
    run_pass(1'b1);
    if (i_bus_xbar_top.i_bus_xbar_assert.fail_count == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("Bus assertions failed %0d times",
               i_bus_xbar_top.i_bus_xbar_assert.fail_count);
      $display("TESTS FAILED");
      $fatal(1);
    end
  end

  initial begin : watchdog
    int limit;
    wait (trace_loaded);
    limit = 2 * trace_q.size() * CYCLES_PER_LINE + RESET_CYCLES;
    repeat (limit) @(posedge clk);
    $display("Timeout: the trace did not complete within %0d cycles", limit);
    $display("TESTS FAILED");
    $fatal(1);
  end

endmodule

`default_nettype wire
